// ==== usb_sniffer.f ====
usb_sniffer_pkg.sv
ulpi_receiver.sv
capture_fifo.sv
uart_tx.sv
capture_ctrl.sv
usb_sniffer_top.sv
usb_sniffer_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module usb_sniffer_tb -f usb_sniffer.f

run: build
	./obj_dir/Vusb_sniffer_tb 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

lint:
	verilator --lint-only --timing --top-module usb_sniffer_top \
		usb_sniffer_pkg.sv ulpi_receiver.sv capture_fifo.sv uart_tx.sv \
		capture_ctrl.sv usb_sniffer_top.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== usb_sniffer_tb.sv ====
// Testbench for the USB sniffer: ULPI packet stimulus, reference model, UART decoder, checks
`timescale 1ns/1ps
`default_nettype none

module usb_sniffer_tb import usb_sniffer_pkg::*; ();

    localparam int FIFO_DEPTH   = 8;
    localparam int CLKS_PER_BIT = 16;
    localparam int CLK_PERIOD   = 8;
    localparam int BURST_LEN    = 20;
    // Directed packets plus the burst
    localparam int NUM_PACKETS  = 7 + BURST_LEN;
    // Four bytes per packet, ten bits per byte, plus margin
    localparam int TIMEOUT_NS   = NUM_PACKETS * 4 * 10 * CLKS_PER_BIT * CLK_PERIOD + 20000;

    // ULPI beat, NXT in bit 8 and DATA below
    typedef logic [8:0] beat_q_t [$];

    logic         clk;
    logic         MASTER_RST;
    logic         dir;
    logic         nxt;
    byte_t        data;
    logic         tx;
    logic [4:0]   leds;

    integer       seed = 32'h3b736853;
    // Packet being built
    beat_q_t      pkt;
    // Expected records in send order
    capture_rec_t exp_q [$];
    // Bytes decoded from the UART line
    byte_t        rx_bytes [$];
    event         byte_done;

    int           errors      = 0;
    int           checks      = 0;
    int           rec_count   = 0;
    int           exp_records = 0;
    // Burst mode lets the FIFO drop records
    logic         allow_drops;
    logic         burst_first;

    usb_sniffer_top #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut_i (
        .clk        (clk),
        .MASTER_RST (MASTER_RST),
        .dir        (dir),
        .nxt        (nxt),
        .data       (data),
        .tx         (tx),
        .leds       (leds)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Receiver rule: first RX CMD, first three data bytes, zeros elsewhere
    function automatic capture_rec_t expected_record(input beat_q_t beats);
        capture_rec_t r;
        int           n;
        logic         cmd_taken;
        r         = '0;
        n         = 0;
        cmd_taken = 1'b0;
        foreach (beats[i]) begin
            if (!beats[i][8]) begin
                if (!cmd_taken) begin
                    r.cmd     = beats[i][7:0];
                    cmd_taken = 1'b1;
                end
            end else begin
                case (n)
                    0: r.pid = beats[i][7:0];
                    1: r.d1  = beats[i][7:0];
                    2: r.d2  = beats[i][7:0];
                    default: ;
                endcase
                n++;
            end
        end
        return r;
    endfunction

    // Packets without data bytes give no record
    function automatic int data_count(input beat_q_t beats);
        int n;
        n = 0;
        foreach (beats[i]) begin
            if (beats[i][8]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic cmd_beat(input byte_t b);
        pkt.push_back({1'b0, b});
    endtask

    task automatic data_beat(input byte_t b);
        pkt.push_back({1'b1, b});
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t: %s expected %02h, got %02h", $time, name, want, got);
        end
    endtask

    // Turnaround, beats, then DIR low for the gap
    task automatic play_packet(input int idle);
        if (data_count(pkt) > 0) begin
            exp_q.push_back(expected_record(pkt));
            exp_records++;
        end
        @(posedge clk);
        dir  <= 1'b1;
        nxt  <= 1'b0;
        data <= 8'h00;
        foreach (pkt[i]) begin
            @(posedge clk);
            nxt  <= pkt[i][8];
            data <= pkt[i][7:0];
        end
        @(posedge clk);
        dir  <= 1'b0;
        nxt  <= 1'b0;
        data <= 8'h00;
        // Busy LED lags DIR by one cycle, still high here
        @(negedge clk);
        check_value("leds[4]", {7'd0, leds[4]}, 8'h01);
        repeat (idle) @(posedge clk);
    endtask

    task automatic random_packet();
        logic [31:0] rnd;
        int          n_data;
        pkt.delete();
        rnd = $random(seed);
        cmd_beat(rnd[7:0]);
        n_data = int'(rnd[31:8] % 24'd5) + 1;
        for (int i = 0; i < n_data; i++) begin
            rnd = $random(seed);
            // Now and then an extra RX CMD between data bytes
            if (rnd[9:8] == 2'b00) begin
                cmd_beat(rnd[23:16]);
            end
            data_beat(rnd[7:0]);
        end
    endtask

    // Push lands about four cycles after DIR falls, then wait for the drain
    task automatic wait_idle();
        repeat (6) @(negedge clk);
        while (!(leds[0] && !leds[3])) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // UART line decoder, sampling mid-bit
    initial begin : uart_decoder
        byte_t b;
        @(negedge MASTER_RST);
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (tx !== 1'b0) begin
                report_failure("start bit on tx ended early");
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    // LSB first
                    b = {tx, b[7:1]};
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                if (tx !== 1'b1) begin
                    report_failure("stop bit on tx is low");
                end
                rx_bytes.push_back(b);
                -> byte_done;
            end
        end
    end

    // Groups of four bytes against the expected queue
    initial begin : compare_records
        capture_rec_t got;
        capture_rec_t want_rec;
        forever begin
            @(byte_done);
            if (rx_bytes.size() >= 4) begin
                got.cmd = rx_bytes.pop_front();
                got.pid = rx_bytes.pop_front();
                got.d1  = rx_bytes.pop_front();
                got.d2  = rx_bytes.pop_front();
                rec_count++;
                if (exp_q.size() == 0) begin
                    report_failure($sformatf("record %08h arrived with no packet pending", got));
                end else begin
                    // Skip dropped records, never before the first one of a burst
                    if (allow_drops && !burst_first) begin
                        while (exp_q.size() > 1 && exp_q[0] != got) begin
                            want_rec = exp_q.pop_front();
                        end
                    end
                    burst_first = 1'b0;
                    want_rec = exp_q.pop_front();
                    check_value("cmd", got.cmd, want_rec.cmd);
                    check_value("pid", got.pid, want_rec.pid);
                    check_value("d1", got.d1, want_rec.d1);
                    check_value("d2", got.d2, want_rec.d2);
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns: UART output never went idle", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin : main_sequence
        int rec_before;
        int burst_recs;
        MASTER_RST  = 1'b1;
        dir         = 1'b0;
        nxt         = 1'b0;
        data        = 8'h00;
        allow_drops = 1'b0;
        burst_first = 1'b0;
        repeat (8) @(posedge clk);
        MASTER_RST <= 1'b0;

        // Idle line, only the empty LED
        repeat (3) @(negedge clk);
        check_value("tx", {7'd0, tx}, 8'h01);
        check_value("leds", {3'd0, leds}, 8'h01);

        // Full packet, two extra bytes dropped
        pkt.delete();
        cmd_beat(8'h5d);
        data_beat(8'hc3);
        data_beat(8'h12);
        data_beat(8'h34);
        data_beat(8'h56);
        data_beat(8'h78);
        play_packet(3);
        wait_idle();

        // Several RX CMDs, one between data bytes
        pkt.delete();
        cmd_beat(8'h5d);
        cmd_beat(8'h4e);
        data_beat(8'h69);
        cmd_beat(8'h1c);
        data_beat(8'h81);
        cmd_beat(8'h1c);
        cmd_beat(8'h1c);
        data_beat(8'h3a);
        play_packet(3);
        pkt.delete();
        cmd_beat(8'h4d);
        data_beat(8'hd2);
        cmd_beat(8'h4d);
        data_beat(8'h11);
        play_packet(3);
        wait_idle();

        // PID only, then DIR pulses without data
        pkt.delete();
        cmd_beat(8'h5d);
        data_beat(8'ha5);
        play_packet(3);
        wait_idle();
        pkt.delete();
        play_packet(3);
        pkt.delete();
        cmd_beat(8'h4d);
        play_packet(3);
        repeat (40) @(negedge clk);
        check_value("leds", {3'd0, leds}, 8'h01);
        if (rec_count != exp_records) begin
            report_failure($sformatf("%0d records on tx, %0d packets with data sent",
                rec_count, exp_records));
        end

        // Burst faster than the UART drains
        rec_before  = rec_count;
        allow_drops = 1'b1;
        burst_first = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            random_packet();
            play_packet(1);
        end
        // FIFO full, overflow latched, drain still on the first record
        repeat (4) @(negedge clk);
        check_value("leds", {3'd0, leds}, 8'h0e);
        wait_idle();
        check_value("leds[2]", {7'd0, leds[2]}, 8'h01);
        check_value("leds[0]", {7'd0, leds[0]}, 8'h01);
        burst_recs = rec_count - rec_before;
        if (burst_first) begin
            report_failure("no record of the burst came out on tx");
        end
        if (burst_recs < FIFO_DEPTH + 1) begin
            report_failure($sformatf("burst gave only %0d records on tx", burst_recs));
        end
        if (burst_recs >= BURST_LEN) begin
            report_failure("burst lost no record although the FIFO overflowed");
        end
        // Records dropped at the tail of the burst
        exp_q.delete();
        allow_drops = 1'b0;

        // Normal capture again, overflow LED still set
        pkt.delete();
        cmd_beat(8'h5d);
        data_beat(8'h2d);
        data_beat(8'h00);
        data_beat(8'h10);
        play_packet(3);
        wait_idle();
        check_value("leds", {3'd0, leds}, 8'h05);

        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected records never came out", exp_q.size()));
        end
        if (rx_bytes.size() != 0) begin
            report_failure($sformatf("%0d stray bytes left on tx", rx_bytes.size()));
        end
        $display("Summary: %0d checks, %0d errors, %0d records", checks, errors, rec_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== usb_sniffer_top.sv ====
// USB sniffer top level: ULPI receiver, capture FIFO, controller and UART transmitter
`timescale 1ns/1ps
`default_nettype none

module usb_sniffer_top import usb_sniffer_pkg::*; #(
    parameter int FIFO_DEPTH   = 8,
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic   clk,
    input  wire logic   MASTER_RST,
    input  wire logic   dir,
    input  wire logic   nxt,
    input  wire byte_t  data,
    output logic        tx,
    output logic [4:0]  leds
);

    // Receiver to controller
    capture_rec_t rec;
    logic         new_packet;
    logic         rx_busy;

    // Controller and FIFO
    logic         push;
    capture_rec_t wr_rec;
    logic         pop;
    capture_rec_t rd_rec;
    logic         full;
    logic         empty;
    logic         overflow;

    // Controller and UART
    byte_t        tx_byte;
    logic         tx_start;
    logic         tx_busy;

    ulpi_receiver receiver_i (
        .clk        (clk),
        .MASTER_RST (MASTER_RST),
        .dir        (dir),
        .nxt        (nxt),
        .data       (data),
        .rec        (rec),
        .new_packet (new_packet),
        .rx_busy    (rx_busy)
    );

    capture_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk        (clk),
        .MASTER_RST (MASTER_RST),
        .push       (push),
        .wr_rec     (wr_rec),
        .pop        (pop),
        .rd_rec     (rd_rec),
        .full       (full),
        .empty      (empty),
        .overflow   (overflow)
    );

    capture_ctrl ctrl_i (
        .clk        (clk),
        .MASTER_RST (MASTER_RST),
        .rec        (rec),
        .new_packet (new_packet),
        .rx_busy    (rx_busy),
        .rd_rec     (rd_rec),
        .full       (full),
        .empty      (empty),
        .overflow   (overflow),
        .tx_busy    (tx_busy),
        .push       (push),
        .wr_rec     (wr_rec),
        .pop        (pop),
        .tx_byte    (tx_byte),
        .tx_start   (tx_start),
        .leds       (leds)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_i (
        .clk        (clk),
        .MASTER_RST (MASTER_RST),
        .tx_byte    (tx_byte),
        .tx_start   (tx_start),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

endmodule

`default_nettype wire

// ==== capture_ctrl.sv ====
// Capture controller: save FSM, drain FSM to the UART, status LEDs
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl import usb_sniffer_pkg::*; (
    input  wire logic          clk,
    input  wire logic          MASTER_RST,
    input  wire capture_rec_t  rec,
    input  wire logic          new_packet,
    input  wire logic          rx_busy,
    input  wire capture_rec_t  rd_rec,
    input  wire logic          full,
    input  wire logic          empty,
    input  wire logic          overflow,
    input  wire logic          tx_busy,
    output logic               push,
    output capture_rec_t       wr_rec,
    output logic               pop,
    output byte_t              tx_byte,
    output logic               tx_start,
    output logic [4:0]         leds
);

    save_state_t  save_state;
    drain_state_t drain_state;

    // Record being sent and position inside it
    capture_rec_t drain_rec;
    logic [1:0]   byte_idx;

    // Overflow seen since reset
    logic ovf_sticky;

    // Save machine
    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            save_state <= SAVE_IDLE;
        end else begin
            case (save_state)
                SAVE_IDLE: begin
                    if (new_packet) begin
                        save_state <= SAVE_WRITE;
                    end
                end
                SAVE_WRITE: begin
                    // One write cycle per packet
                    save_state <= SAVE_IDLE;
                end
                default: save_state <= SAVE_IDLE;
            endcase
        end
    end

    // Record held for the write cycle
    always_ff @(posedge clk) begin
        if (new_packet) begin
            wr_rec <= rec;
        end
    end

    assign push = (save_state == SAVE_WRITE);

    // Drain machine
    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            drain_state <= DRAIN_IDLE;
            byte_idx    <= 2'd0;
        end else begin
            case (drain_state)
                DRAIN_IDLE: begin
                    if (!empty) begin
                        drain_state <= DRAIN_POP;
                    end
                end
                DRAIN_POP: begin
                    byte_idx    <= 2'd0;
                    drain_state <= DRAIN_SEND;
                end
                DRAIN_SEND: begin
                    // UART busy rises on the same edge
                    drain_state <= DRAIN_WAIT;
                end
                DRAIN_WAIT: begin
                    if (!tx_busy) begin
                        if (byte_idx == 2'd3) begin
                            drain_state <= DRAIN_IDLE;
                        end else begin
                            byte_idx    <= byte_idx + 2'd1;
                            drain_state <= DRAIN_SEND;
                        end
                    end
                end
                default: drain_state <= DRAIN_IDLE;
            endcase
        end
    end

    // Head latched while it is popped
    always_ff @(posedge clk) begin
        if (drain_state == DRAIN_POP) begin
            drain_rec <= rd_rec;
        end
    end

    assign pop      = (drain_state == DRAIN_POP);
    assign tx_start = (drain_state == DRAIN_SEND);

    // Byte order on the line is CMD, PID, D1, D2
    always_comb begin
        case (byte_idx)
            2'd0:    tx_byte = drain_rec.cmd;
            2'd1:    tx_byte = drain_rec.pid;
            2'd2:    tx_byte = drain_rec.d1;
            default: tx_byte = drain_rec.d2;
        endcase
    end

    // Status LEDs
    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            ovf_sticky <= 1'b0;
            leds       <= 5'd0;
        end else begin
            if (overflow) begin
                ovf_sticky <= 1'b1;
            end
            leds[0] <= empty;
            leds[1] <= full;
            leds[2] <= ovf_sticky || overflow;
            leds[3] <= (drain_state != DRAIN_IDLE);
            leds[4] <= rx_busy;
        end
    end

    // A byte is only started on an idle transmitter
    assert property (@(posedge clk) disable iff (MASTER_RST)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
// UART 8N1 transmitter, LSB first, bit period set by parameter
`timescale 1ns/1ps
`default_nettype none

module uart_tx import usb_sniffer_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic   clk,
    input  wire logic   MASTER_RST,
    input  wire byte_t  tx_byte,
    input  wire logic   tx_start,
    output logic        tx,
    output logic        tx_busy
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    // Clocks inside one bit period
    typedef logic [CNT_W-1:0] bit_cnt_t;

    bit_cnt_t   clk_cnt;
    // Bits already sent in the frame
    logic [3:0] bit_idx;
    // Stop, data, start; bit 0 is on the line
    logic [9:0] shift;

    // Idle line is high, all ones once the frame is out
    assign tx = shift[0];

    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            clk_cnt <= '0;
            bit_idx <= 4'd0;
            shift   <= '1;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Frame loaded, start bit goes out next cycle
                shift   <= {1'b1, tx_byte, 1'b0};
                clk_cnt <= '0;
                bit_idx <= 4'd0;
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            // Ones shifted in keep the line high after stop
            shift   <= {1'b1, shift[9:1]};
            if (bit_idx == 4'd9) begin
                // End of stop bit
                tx_busy <= 1'b0;
            end else begin
                bit_idx <= bit_idx + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + bit_cnt_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== capture_fifo.sv ====
// Synchronous capture record FIFO with full, empty and overflow flags
`timescale 1ns/1ps
`default_nettype none

module capture_fifo import usb_sniffer_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic          clk,
    input  wire logic          MASTER_RST,
    input  wire logic          push,
    input  wire capture_rec_t  wr_rec,
    input  wire logic          pop,
    output capture_rec_t       rd_rec,
    output logic               full,
    output logic               empty,
    output logic               overflow
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // Pointer and occupancy widths
    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    capture_rec_t mem [FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    // Accepted strobes
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == cnt_t'(FIFO_DEPTH));
    assign empty = (count == '0);

    // Head of queue, valid while not empty
    assign rd_rec = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Dropped push flagged for one cycle
            overflow <= push && full;
            if (do_push) begin
                // Depth is a power of two, pointers wrap by themselves
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            if (do_push && !do_pop) begin
                count <= count + cnt_t'(1);
            end else if (do_pop && !do_push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_rec;
        end
    end

    // Controller must not pop an empty FIFO
    assert property (@(posedge clk) disable iff (MASTER_RST)
        pop |-> !empty);

endmodule

`default_nettype wire

// ==== ulpi_receiver.sv ====
// ULPI receive path: turnaround tracking, RX CMD and data byte capture, packet-end pulse
`timescale 1ns/1ps
`default_nettype none

module ulpi_receiver import usb_sniffer_pkg::*; (
    input  wire logic         clk,
    input  wire logic         MASTER_RST,
    input  wire logic         dir,
    input  wire logic         nxt,
    input  wire byte_t        data,
    output capture_rec_t      rec,
    output logic              new_packet,
    output logic              rx_busy
);

    // DIR one cycle back, for edge detection
    logic       dir_q;
    // First RX CMD already taken
    logic       cmd_seen;
    // Data bytes captured so far, stops at three
    logic [1:0] data_cnt;

    // Turnaround is the first cycle with DIR high
    logic dir_rise;
    // First cycle with DIR seen low again
    logic dir_fall;
    // Bus owned by the PHY and past turnaround
    logic rx_active;

    assign dir_rise  = dir && !dir_q;
    assign dir_fall  = !dir && dir_q;
    assign rx_active = dir && dir_q;

    // Busy while the PHY drives the bus
    assign rx_busy = dir;

    always_ff @(posedge clk) begin
        if (MASTER_RST) begin
            dir_q      <= 1'b0;
            cmd_seen   <= 1'b0;
            data_cnt   <= 2'd0;
            new_packet <= 1'b0;
        end else begin
            dir_q      <= dir;
            // Pulse only when the packet carried data
            new_packet <= dir_fall && (data_cnt != 2'd0);

            if (dir_rise) begin
                // New packet, start from a clean record
                cmd_seen <= 1'b0;
                data_cnt <= 2'd0;
            end else if (rx_active) begin
                if (!nxt) begin
                    // RX CMD, later ones are dropped
                    cmd_seen <= 1'b1;
                end else if (data_cnt != 2'd3) begin
                    data_cnt <= data_cnt + 2'd1;
                end
            end
        end
    end

    // Record fields, payload only
    always_ff @(posedge clk) begin
        if (dir_rise) begin
            rec <= '0;
        end else if (rx_active) begin
            if (!nxt) begin
                if (!cmd_seen) begin
                    rec.cmd <= data;
                end
            end else begin
                // Data bytes land in order, extra bytes ignored
                case (data_cnt)
                    2'd0: rec.pid <= data;
                    2'd1: rec.d1  <= data;
                    2'd2: rec.d2  <= data;
                    default: ;
                endcase
            end
        end
    end

    // Packet end never flagged while the PHY owns the bus
    assert property (@(posedge clk) disable iff (MASTER_RST)
        new_packet |-> !dir);

endmodule

`default_nettype wire

// ==== usb_sniffer_pkg.sv ====
// Shared types for the USB sniffer: data byte, capture record, controller FSM states
`default_nettype none

package usb_sniffer_pkg;

    // One byte on the ULPI data bus or the UART path
    typedef logic [7:0] byte_t;

    // One captured packet
    // Field order is also the order on the UART
    // Fields not seen in the packet read as zero
    typedef struct packed {
        // First RX CMD byte of the packet
        byte_t cmd;
        // First data byte
        byte_t pid;
        // Second data byte
        byte_t d1;
        // Third data byte
        byte_t d2;
    } capture_rec_t;

    // Save machine
    // Idle until the receiver flags a packet, then one write cycle
    typedef enum logic {
        SAVE_IDLE,
        SAVE_WRITE
    } save_state_t;

    // Drain machine
    // Pop one record, then send its four bytes one after another
    typedef enum logic [1:0] {
        // Waiting for a record in the FIFO
        DRAIN_IDLE,
        // Pop strobe, head record latched
        DRAIN_POP,
        // Start strobe for the current byte
        DRAIN_SEND,
        // Byte on the line
        DRAIN_WAIT
    } drain_state_t;

endpackage

`default_nettype wire
